//--- hdl/lsu_acc_classifier.sv
//////////////////////////////////////////////////
// access class, transfer size and capability room
// check, sent out on the four-phase result side
//////////////////////////////////////////////////

`include "lsu_mon_defs.svh"

`timescale 1ns/1ps
`default_nettype none

module lsu_acc_classifier (
  input  logic                clk_i,
  input  logic                rst_ni,
  lsu_req_if.pop              pop,
  output logic                res_req_o,
  input  logic                res_ack_i,
  output lsu_pkg::lsu_addr_t  res_addr_o,
  output mon_pkg::acc_class_t res_class_o,
  output mon_pkg::xfer_size_t res_size_o,
  output mon_pkg::room_chk_t  res_room_o
);

  mon_pkg::res_fsm_e   res_state_q;
  mon_pkg::res_fsm_e   res_state_d;
  mon_pkg::acc_class_t acc_class;
  mon_pkg::xfer_size_t xfer_size;
  mon_pkg::room_chk_t  room_chk;
  lsu_pkg::cap_top_t   addr_ext;
  lsu_pkg::cap_top_t   size_ext;
  lsu_pkg::cap_top_t   room_left;
  logic                top_below;
  logic                word_aligned;
  logic                half_aligned;
  logic                take;

  //////////////////////////////////////////////////
  // classification of the head entry
  //////////////////////////////////////////////////

  assign word_aligned = (pop.addr[1:0] == 2'b00);
  assign half_aligned = !pop.addr[0];

  always_comb begin
    acc_class = `LSU_ACC_NULL;
    xfer_size = 4'd1;
    if (pop.is_cap) begin
      xfer_size = 4'd8;
      acc_class = pop.we ? `LSU_ACC_CAP_WR : `LSU_ACC_CAP_RD;
    end else begin
      case (pop.lsu_type)
        `LSU_TYPE_WORD: begin
          xfer_size = 4'd4;
          if (pop.we) begin
            acc_class = word_aligned ? `LSU_ACC_WORD_WR_ALIGNED : `LSU_ACC_WORD_WR_UNALIGNED;
          end else begin
            acc_class = word_aligned ? `LSU_ACC_WORD_RD_ALIGNED : `LSU_ACC_WORD_RD_UNALIGNED;
          end
        end
        `LSU_TYPE_HALF: begin
          xfer_size = 4'd2;
          if (pop.we) begin
            acc_class = half_aligned ? `LSU_ACC_HW_WR_ALIGNED : `LSU_ACC_HW_WR_UNALIGNED;
          end else begin
            acc_class = half_aligned ? `LSU_ACC_HW_RD_ALIGNED : `LSU_ACC_HW_RD_UNALIGNED;
          end
        end
        // byte type and the unused code
        default: begin
          acc_class = pop.we ? `LSU_ACC_BYTE_WR : `LSU_ACC_BYTE_RD;
        end
      endcase
    end
  end

  // room left in the capability above the access address
  assign addr_ext  = {1'b0, pop.addr};
  assign size_ext  = lsu_pkg::cap_top_t'(xfer_size);
  assign top_below = (pop.cap_top < addr_ext);
  assign room_left = pop.cap_top - addr_ext;

  always_comb begin
    if (top_below || (room_left < size_ext)) begin
      room_chk = `LSU_ROOM_LESS;
    end else if (room_left == size_ext) begin
      room_chk = `LSU_ROOM_EQUAL;
    end else begin
      room_chk = `LSU_ROOM_MORE;
    end
  end

  //////////////////////////////////////////////////
  // result handshake
  //////////////////////////////////////////////////

  assign pop.ready = (res_state_q == mon_pkg::RES_IDLE);
  assign take      = pop.valid && pop.ready;

  always_comb begin
    res_state_d = res_state_q;
    case (res_state_q)
      mon_pkg::RES_IDLE: begin
        if (take) begin
          res_state_d = mon_pkg::RES_SEND;
        end
      end
      mon_pkg::RES_SEND: begin
        if (res_ack_i) begin
          res_state_d = mon_pkg::RES_RELEASE;
        end
      end
      // wait for the ack to drop before the next pop
      mon_pkg::RES_RELEASE: begin
        if (!res_ack_i) begin
          res_state_d = mon_pkg::RES_IDLE;
        end
      end
      default: res_state_d = mon_pkg::RES_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_state_q <= mon_pkg::RES_IDLE;
    end else begin
      res_state_q <= res_state_d;
    end
  end

  // result payload, loaded only on a pop so it holds through the handshake
  always_ff @(posedge clk_i) begin
    if (take) begin
      res_addr_o  <= pop.addr;
      res_class_o <= acc_class;
      res_size_o  <= xfer_size;
      res_room_o  <= room_chk;
    end
  end

  assign res_req_o = (res_state_q == mon_pkg::RES_SEND);

endmodule

`default_nettype wire

//--- hdl/lsu_access_monitor.sv
//////////////////////////////////////////////////
// load/store access monitor top level
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_access_monitor (
  input  logic                clk_i,
  input  logic                rst_ni,
  // request side
  input  logic                req_i,
  output logic                ack_o,
  input  lsu_pkg::lsu_addr_t  req_addr_i,
  input  lsu_pkg::lsu_type_t  req_type_i,
  input  logic                req_we_i,
  input  logic                req_is_cap_i,
  input  lsu_pkg::cap_top_t   req_cap_top_i,
  // result side
  output logic                res_req_o,
  input  logic                res_ack_i,
  output lsu_pkg::lsu_addr_t  res_addr_o,
  output mon_pkg::acc_class_t res_class_o,
  output mon_pkg::xfer_size_t res_size_o,
  output mon_pkg::room_chk_t  res_room_o
);

  // capture to FIFO, and FIFO head to classifier
  lsu_req_if req_push_if ();
  lsu_req_if req_pop_if ();

  lsu_req_capture u_capture (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .ack_o         (ack_o),
    .req_addr_i    (req_addr_i),
    .req_type_i    (req_type_i),
    .req_we_i      (req_we_i),
    .req_is_cap_i  (req_is_cap_i),
    .req_cap_top_i (req_cap_top_i),
    .push          (req_push_if.push)
  );

  lsu_req_fifo u_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push   (req_push_if.pop),
    .pop    (req_pop_if.push)
  );

  lsu_acc_classifier u_classifier (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .pop         (req_pop_if.pop),
    .res_req_o   (res_req_o),
    .res_ack_i   (res_ack_i),
    .res_addr_o  (res_addr_o),
    .res_class_o (res_class_o),
    .res_size_o  (res_size_o),
    .res_room_o  (res_room_o)
  );

endmodule

`default_nettype wire

//--- hdl/lsu_mon_defs.svh
//////////////////////////////////////////////////
// widths, FIFO depth and code macros shared by the
// load/store access monitor RTL and its testbench
//////////////////////////////////////////////////

`ifndef LSU_MON_DEFS_SVH
`define LSU_MON_DEFS_SVH

// widths
`define LSU_ADDR_W      32
`define LSU_CAP_TOP_W   33
`define LSU_TYPE_W      2
`define LSU_CLASS_W     4
`define LSU_SIZE_W      4
`define LSU_ROOM_W      2

// number of buffered requests
`define LSU_FIFO_DEPTH  4

// rv32 size type
`define LSU_TYPE_WORD   2'd0
`define LSU_TYPE_HALF   2'd1
`define LSU_TYPE_BYTE   2'd2

// access classes
`define LSU_ACC_NULL              4'd0
`define LSU_ACC_CAP_RD            4'd1
`define LSU_ACC_CAP_WR            4'd2
`define LSU_ACC_BYTE_RD           4'd3
`define LSU_ACC_BYTE_WR           4'd4
`define LSU_ACC_HW_RD_ALIGNED     4'd5
`define LSU_ACC_HW_RD_UNALIGNED   4'd6
`define LSU_ACC_HW_WR_ALIGNED     4'd7
`define LSU_ACC_HW_WR_UNALIGNED   4'd8
`define LSU_ACC_WORD_RD_ALIGNED   4'd9
`define LSU_ACC_WORD_RD_UNALIGNED 4'd10
`define LSU_ACC_WORD_WR_ALIGNED   4'd11
`define LSU_ACC_WORD_WR_UNALIGNED 4'd12

// capability room check
`define LSU_ROOM_MORE   2'd0
`define LSU_ROOM_EQUAL  2'd1
`define LSU_ROOM_LESS   2'd2

`endif

//--- hdl/lsu_pkg.sv
//////////////////////////////////////////////////
// request-side types of a cpu load/store access
//////////////////////////////////////////////////

`include "lsu_mon_defs.svh"

`default_nettype none

package lsu_pkg;

  // byte address of the access
  typedef logic [`LSU_ADDR_W-1:0] lsu_addr_t;

  // rv32 size type, see LSU_TYPE_* codes
  typedef logic [`LSU_TYPE_W-1:0] lsu_type_t;

  // top of the authorising capability
  // one bit wider than the address so a top of 2**32 fits
  typedef logic [`LSU_CAP_TOP_W-1:0] cap_top_t;

endpackage

`default_nettype wire

//--- hdl/lsu_req_capture.sv
//////////////////////////////////////////////////
// four-phase request receiver, one push per request
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_req_capture (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  output logic               ack_o,
  input  lsu_pkg::lsu_addr_t req_addr_i,
  input  lsu_pkg::lsu_type_t req_type_i,
  input  logic               req_we_i,
  input  logic               req_is_cap_i,
  input  lsu_pkg::cap_top_t  req_cap_top_i,
  lsu_req_if.push            push
);

  mon_pkg::cap_fsm_e cap_state_q;
  mon_pkg::cap_fsm_e cap_state_d;
  logic              push_taken;

  // payload is held stable by the requester until ack
  assign push.addr     = req_addr_i;
  assign push.lsu_type = req_type_i;
  assign push.we       = req_we_i;
  assign push.is_cap   = req_is_cap_i;
  assign push.cap_top  = req_cap_top_i;

  // offer the request only once, before it is acknowledged
  assign push.valid = (cap_state_q == mon_pkg::WAIT_REQ) && req_i;
  assign push_taken = push.valid && push.ready;

  //////////////////////////////////////////////////
  // receiver FSM
  //////////////////////////////////////////////////

  always_comb begin
    cap_state_d = cap_state_q;
    case (cap_state_q)
      mon_pkg::WAIT_REQ: begin
        // a full FIFO keeps the request waiting
        if (push_taken) begin
          cap_state_d = mon_pkg::WAIT_DROP;
        end
      end
      mon_pkg::WAIT_DROP: begin
        if (!req_i) begin
          cap_state_d = mon_pkg::WAIT_REQ;
        end
      end
      default: cap_state_d = mon_pkg::WAIT_REQ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cap_state_q <= mon_pkg::WAIT_REQ;
    end else begin
      cap_state_q <= cap_state_d;
    end
  end

  // ack is high for the whole of WAIT_DROP, rises the cycle after the push
  assign ack_o = (cap_state_q == mon_pkg::WAIT_DROP);

endmodule

`default_nettype wire

//--- hdl/lsu_req_fifo.sv
//////////////////////////////////////////////////
// request FIFO, circular buffer with wrap-bit
// pointers
//////////////////////////////////////////////////

`include "lsu_mon_defs.svh"

`timescale 1ns/1ps
`default_nettype none

module lsu_req_fifo (
  input  logic     clk_i,
  input  logic     rst_ni,
  // write side, this module is the receiver
  lsu_req_if.pop   push,
  // read side, this module is the sender
  lsu_req_if.push  pop
);

  localparam int unsigned depth = `LSU_FIFO_DEPTH;
  localparam int unsigned idx_w = $clog2(depth);

  // pointers carry one extra wrap bit
  logic [idx_w:0] wr_ptr_q;
  logic [idx_w:0] rd_ptr_q;
  logic           full;
  logic           empty;
  logic           do_push;
  logic           do_pop;

  // storage
  lsu_pkg::lsu_addr_t addr_mem    [depth];
  lsu_pkg::lsu_type_t type_mem    [depth];
  logic               we_mem      [depth];
  logic               is_cap_mem  [depth];
  lsu_pkg::cap_top_t  cap_top_mem [depth];

  assign empty = (wr_ptr_q == rd_ptr_q);
  assign full  = (wr_ptr_q[idx_w] != rd_ptr_q[idx_w]) &&
                 (wr_ptr_q[idx_w-1:0] == rd_ptr_q[idx_w-1:0]);

  assign push.ready = !full;
  assign pop.valid  = !empty;

  assign do_push = push.valid && push.ready;
  assign do_pop  = pop.valid && pop.ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      addr_mem[wr_ptr_q[idx_w-1:0]]    <= push.addr;
      type_mem[wr_ptr_q[idx_w-1:0]]    <= push.lsu_type;
      we_mem[wr_ptr_q[idx_w-1:0]]      <= push.we;
      is_cap_mem[wr_ptr_q[idx_w-1:0]]  <= push.is_cap;
      cap_top_mem[wr_ptr_q[idx_w-1:0]] <= push.cap_top;
    end
  end

  // head entry, straight from the storage registers
  assign pop.addr     = addr_mem[rd_ptr_q[idx_w-1:0]];
  assign pop.lsu_type = type_mem[rd_ptr_q[idx_w-1:0]];
  assign pop.we       = we_mem[rd_ptr_q[idx_w-1:0]];
  assign pop.is_cap   = is_cap_mem[rd_ptr_q[idx_w-1:0]];
  assign pop.cap_top  = cap_top_mem[rd_ptr_q[idx_w-1:0]];

endmodule

`default_nettype wire

//--- hdl/lsu_req_if.sv
//////////////////////////////////////////////////
// one buffered request with valid/ready
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface lsu_req_if;

  // handshake, transfer on an edge with both high
  logic valid;
  logic ready;

  // request payload
  lsu_pkg::lsu_addr_t addr;
  lsu_pkg::lsu_type_t lsu_type;
  logic               we;
  logic               is_cap;
  lsu_pkg::cap_top_t  cap_top;

  // sender side
  modport push (output valid, addr, lsu_type, we, is_cap, cap_top,
                input  ready);

  // receiver side
  modport pop  (input  valid, addr, lsu_type, we, is_cap, cap_top,
                output ready);

endinterface

`default_nettype wire

//--- hdl/mon_pkg.sv
//////////////////////////////////////////////////
// result-side types and FSM states of the monitor
//////////////////////////////////////////////////

`include "lsu_mon_defs.svh"

`default_nettype none

package mon_pkg;

  // access class, a LSU_ACC_* code
  typedef logic [`LSU_CLASS_W-1:0] acc_class_t;

  // transfer size in bytes (8, 4, 2 or 1)
  typedef logic [`LSU_SIZE_W-1:0] xfer_size_t;

  // room check, a LSU_ROOM_* code
  typedef logic [`LSU_ROOM_W-1:0] room_chk_t;

  // four-phase request receiver
  typedef enum logic {WAIT_REQ, WAIT_DROP} cap_fsm_e;

  // four-phase result sender
  typedef enum logic [1:0] {RES_IDLE, RES_SEND, RES_RELEASE} res_fsm_e;

endpackage

`default_nettype wire

//--- lsu_access_monitor.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/mon_pkg.sv
hdl/lsu_req_if.sv
hdl/lsu_req_capture.sv
hdl/lsu_req_fifo.sv
hdl/lsu_acc_classifier.sv
hdl/lsu_access_monitor.sv
test/lsu_access_monitor_chk.sv
test/tb_lsu_access_monitor.sv

//--- test/lsu_access_monitor_chk.sv
//////////////////////////////////////////////////
// handshake assertions bound to the monitor top
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_access_monitor_chk (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                req_i,
  input logic                ack_o,
  input logic                res_req_o,
  input logic                res_ack_i,
  input lsu_pkg::lsu_addr_t  res_addr_o,
  input mon_pkg::acc_class_t res_class_o,
  input mon_pkg::xfer_size_t res_size_o,
  input mon_pkg::room_chk_t  res_room_o
);

  // ack only answers a raised request
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(ack_o) |-> req_i)
    else $error("ack_o rose while req_i was low");

  // result request is withdrawn only after the consumer acknowledged
  res_drop_after_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(res_req_o) |-> $past(res_ack_i))
    else $error("res_req_o fell without res_ack_i");

  // payload held for the whole result request
  res_payload_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_req_o && $past(res_req_o) |->
      $stable(res_addr_o) && $stable(res_class_o) &&
      $stable(res_size_o) && $stable(res_room_o))
    else $error("result payload changed while res_req_o was high");

  // both handshakes quiet in reset, skipping the first edge
  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni && $past(!rst_ni) |-> !ack_o && !res_req_o)
    else $error("handshake output high during reset");

endmodule

bind lsu_access_monitor lsu_access_monitor_chk u_chk (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .req_i       (req_i),
  .ack_o       (ack_o),
  .res_req_o   (res_req_o),
  .res_ack_i   (res_ack_i),
  .res_addr_o  (res_addr_o),
  .res_class_o (res_class_o),
  .res_size_o  (res_size_o),
  .res_room_o  (res_room_o)
);

`default_nettype wire

//--- test/lsu_mon_tests.txt
# we is_cap type addr cap_top | expected class size room, all hex
# class codes follow LSU_ACC_*, room 0 more, 1 equal, 2 less
0 1 0 00001000 000002000 1 8 0
1 1 0 00001010 000001018 2 8 1
0 0 0 00002000 000003000 9 4 0
0 0 0 00002002 000003000 a 4 0
1 0 0 00002004 000002008 b 4 1
1 0 0 00002007 000003000 c 4 0
0 0 1 00003002 000003004 5 2 1
0 0 1 00003005 000004000 6 2 0
1 0 1 00003008 000004000 7 2 0
1 0 1 00003009 00000300a 8 2 2
0 0 2 00004001 000004002 3 1 1
1 0 2 00004003 000005000 4 1 0
0 0 2 00004004 000004004 3 1 2
1 0 2 00004005 000004000 4 1 2
0 1 0 00005000 000005007 1 8 2
1 1 0 00005010 000005019 2 8 0
0 0 0 fffffffc 100000000 9 4 1
1 0 1 fffffffe 100000000 7 2 1
0 0 2 ffffffff 0ffffffff 3 1 2
1 1 0 fffffff8 100000000 2 8 1
0 0 0 00006003 000006006 a 4 2
0 0 3 00007000 000008000 3 1 0

//--- test/tb_lsu_access_monitor.sv
//////////////////////////////////////////////////
// testbench for the access monitor with requests
// and expected results read from a vector file
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_lsu_access_monitor;

  localparam int unsigned ack_timeout = 100;
  localparam int unsigned res_timeout = 200;
  localparam int unsigned full_wait   = 30;
  localparam string       vec_file    = "test/lsu_mon_tests.txt";

  logic                clk_i;
  logic                rst_ni;
  logic                req_i;
  logic                ack_o;
  lsu_pkg::lsu_addr_t  req_addr_i;
  lsu_pkg::lsu_type_t  req_type_i;
  logic                req_we_i;
  logic                req_is_cap_i;
  lsu_pkg::cap_top_t   req_cap_top_i;
  logic                res_req_o;
  logic                res_ack_i;
  lsu_pkg::lsu_addr_t  res_addr_o;
  mon_pkg::acc_class_t res_class_o;
  mon_pkg::xfer_size_t res_size_o;
  mon_pkg::room_chk_t  res_room_o;

  // one entry per request line of the vector file
  logic                vec_we[$];
  logic                vec_cap[$];
  lsu_pkg::lsu_type_t  vec_type[$];
  lsu_pkg::lsu_addr_t  vec_addr[$];
  lsu_pkg::cap_top_t   vec_top[$];
  mon_pkg::acc_class_t vec_class[$];
  mon_pkg::xfer_size_t vec_size[$];
  mon_pkg::room_chk_t  vec_room[$];

  int seed = 49878;
  int check_count;
  int error_count;
  int timeout_count;

  lsu_access_monitor UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic check_flag(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("Error: %s expected 0x%h got 0x%h", name, exp, act);
    end
  endtask

  task automatic check_addr(input int idx, input lsu_pkg::lsu_addr_t exp, act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("Error: res_addr_o (request %0d) expected 0x%h got 0x%h", idx, exp, act);
    end
  endtask

  task automatic check_class(input int idx, input mon_pkg::acc_class_t exp, act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("Error: res_class_o (request %0d) expected 0x%h got 0x%h", idx, exp, act);
    end
  endtask

  task automatic check_size(input int idx, input mon_pkg::xfer_size_t exp, act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("Error: res_size_o (request %0d) expected 0x%h got 0x%h", idx, exp, act);
    end
  endtask

  task automatic check_room(input int idx, input mon_pkg::room_chk_t exp, act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("Error: res_room_o (request %0d) expected 0x%h got 0x%h", idx, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // handshake helpers sampling outputs on the falling edge
  //////////////////////////////////////////////////

  task automatic wait_ack(input logic level, input int unsigned limit, output bit seen);
    int unsigned n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < limit) begin
      @(negedge clk_i);
      seen = (ack_o === level);
      n++;
    end
  endtask

  task automatic wait_res(input logic level, input int unsigned limit, output bit seen);
    int unsigned n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < limit) begin
      @(negedge clk_i);
      seen = (res_req_o === level);
      n++;
    end
  endtask

  task automatic raise_request(input int idx);
    @(posedge clk_i);
    req_i         <= 1'b1;
    req_addr_i    <= vec_addr[idx];
    req_type_i    <= vec_type[idx];
    req_we_i      <= vec_we[idx];
    req_is_cap_i  <= vec_cap[idx];
    req_cap_top_i <= vec_top[idx];
  endtask

  task automatic drop_request();
    bit seen;
    @(posedge clk_i);
    req_i <= 1'b0;
    wait_ack(1'b0, ack_timeout, seen);
    if (!seen) begin
      timeout_count++;
      $display("ack_o stayed high after the request was dropped");
    end
  endtask

  task automatic send_request(input int idx);
    bit seen;
    raise_request(idx);
    wait_ack(1'b1, ack_timeout, seen);
    if (!seen) begin
      timeout_count++;
      $display("request %0d was not acknowledged before the timeout", idx);
    end
    drop_request();
  endtask

  // results come back in request order and are acked after 0 to 3 cycles
  task automatic receive_results(input int first, input int count);
    bit seen;
    int delay;
    for (int k = 0; k < count; k++) begin
      wait_res(1'b1, res_timeout, seen);
      if (!seen) begin
        timeout_count++;
        $display("no result for request %0d arrived before the timeout", first + k);
        return;
      end
      check_addr(first + k, vec_addr[first + k], res_addr_o);
      check_class(first + k, vec_class[first + k], res_class_o);
      check_size(first + k, vec_size[first + k], res_size_o);
      check_room(first + k, vec_room[first + k], res_room_o);
      delay = $unsigned($random(seed)) % 4;
      repeat (delay) @(posedge clk_i);
      @(posedge clk_i);
      res_ack_i <= 1'b1;
      wait_res(1'b0, res_timeout, seen);
      if (!seen) begin
        timeout_count++;
        $display("res_req_o stayed high after the result was acknowledged");
      end
      @(posedge clk_i);
      res_ack_i <= 1'b0;
    end
  endtask

  task automatic load_vectors();
    int          fd;
    string       line;
    logic [35:0] v [8];
    fd = $fopen(vec_file, "r");
    if (fd == 0) begin
      error_count++;
      $display("could not open the vector file %s", vec_file);
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) != 0) begin
        // comment and blank lines fail the scan and are skipped
        if ($sscanf(line, "%h %h %h %h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]) == 8) begin
          vec_we.push_back(v[0][0]);
          vec_cap.push_back(v[1][0]);
          vec_type.push_back(lsu_pkg::lsu_type_t'(v[2]));
          vec_addr.push_back(lsu_pkg::lsu_addr_t'(v[3]));
          vec_top.push_back(lsu_pkg::cap_top_t'(v[4]));
          vec_class.push_back(mon_pkg::acc_class_t'(v[5]));
          vec_size.push_back(mon_pkg::xfer_size_t'(v[6]));
          vec_room.push_back(mon_pkg::room_chk_t'(v[7]));
        end
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    int base;
    bit seen;
    rst_ni        = 1'b0;
    req_i         = 1'b0;
    req_addr_i    = '0;
    req_type_i    = '0;
    req_we_i      = 1'b0;
    req_is_cap_i  = 1'b0;
    req_cap_top_i = '0;
    res_ack_i     = 1'b0;
    check_count   = 0;
    error_count   = 0;
    timeout_count = 0;
    load_vectors();
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_flag("ack_o", 1'b0, ack_o);
    check_flag("res_req_o", 1'b0, res_req_o);
    // no handshake activity before the first request
    repeat (8) begin
      @(negedge clk_i);
      check_flag("ack_o", 1'b0, ack_o);
      check_flag("res_req_o", 1'b0, res_req_o);
    end
    if (vec_addr.size() < 6) begin
      error_count++;
      $display("the vector file holds fewer than six requests");
    end else begin
      // every vector in turn while the consumer acks with random delays
      fork
        begin
          for (int i = 0; i < vec_addr.size(); i++) begin
            send_request(i);
          end
        end
        receive_results(0, vec_addr.size());
      join
      // stalled consumer leaves four in the FIFO and one in the result register
      base = vec_addr.size() - 6;
      for (int i = 0; i < 5; i++) begin
        send_request(base + i);
      end
      raise_request(base + 5);
      wait_ack(1'b1, full_wait, seen);
      if (seen) begin
        error_count++;
        $display("sixth request was acknowledged while five were pending");
      end
      fork
        begin
          wait_ack(1'b1, ack_timeout, seen);
          if (!seen) begin
            timeout_count++;
            $display("sixth request was not acknowledged after results drained");
          end
          drop_request();
        end
        receive_results(base, 6);
      join
    end
    $display("checks: %0d, mismatches: %0d, timeouts: %0d",
             check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
